// ==== logic/qspi_pkg.sv ====
package qspi_pkg;

    // Quad Output Fast Read, 1-1-4
    localparam logic [7:0] CMD_QUAD_READ = 8'h6B;
    localparam int         ADDR_BYTES    = 3;
    localparam int         DUMMY_BYTES   = 1;

    // Bus width used by the PHY for one byte
    typedef enum logic {
        SPI_MODE  = 1'b0, // io0 out, io1 in
        QUAD_MODE = 1'b1  // io3..io0, high nibble first
    } qspi_mode_e;

    typedef enum logic [2:0] {
        S_IDLE  = 3'd0,
        S_CMD   = 3'd1,
        S_ADDR  = 3'd2,
        S_DUMMY = 3'd3,
        S_DATA  = 3'd4,
        S_END   = 3'd5
    } seq_state_e;

    // One read request from the outside
    typedef struct packed {
        logic [23:0] addr;  // Byte address in flash
        logic [7:0]  words; // Number of 32-bit words, 1 to 255
    } read_req_t;

    // One byte handed to the PHY
    typedef struct packed {
        logic [7:0] data;
        qspi_mode_e mode;
        logic       drive; // PHY owns the pins for this byte
    } byte_xfer_t;

    // Data byte on its way to the packer
    typedef struct packed {
        logic [7:0] data;
        logic       last; // Final byte of the read
    } rx_byte_t;

endpackage

// ==== logic/flash_read_req.sv ====
`timescale 1ns/1ns

module flash_read_req (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                req_valid_i,
    input  qspi_pkg::read_req_t req_i,
    input  logic                take_i,
    output logic                pend_o,
    output qspi_pkg::read_req_t req_o,
    output logic                drop_o
);
    import qspi_pkg::*;

    read_req_t slot_q;
    logic      valid_q;
    logic      drop_q;
    logic      load;

    // Slot is free now or frees up at this edge
    assign load = req_valid_i & (~valid_q | take_i);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
            drop_q  <= 1'b0;
        end else begin
            valid_q <= load | (valid_q & ~take_i);
            drop_q  <= req_valid_i & ~load; // Slot full, request lost
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            slot_q <= req_i;
        end
    end

    assign pend_o = valid_q;
    assign req_o  = slot_q;
    assign drop_o = drop_q;

    // The sequencer may only take what is actually held
    a_take_needs_pend: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        take_i |-> pend_o
    ) else $error("take without pending request");

endmodule

// ==== logic/qspi_byte_phy.sv ====
`timescale 1ns/1ns

module qspi_byte_phy (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 start_i,
    input  qspi_pkg::byte_xfer_t xfer_i,
    output logic                 busy_o,
    output logic                 done_o,
    output logic [7:0]           rx_o,
    output logic                 sck_o,
    output logic [3:0]           io_o,
    output logic [3:0]           io_oe_o,
    input  logic [3:0]           io_i
);
    import qspi_pkg::*;

    logic       active_q;
    logic       sck_q;
    logic       done_q;
    logic       drive_q;
    qspi_mode_e mode_q;
    logic [3:0] edge_q;  // sck half periods seen in this byte
    logic [7:0] shift_q; // Outgoing bits at the top, incoming at the bottom
    logic       last_edge;

    // 16 half periods for SPI, 4 for quad
    assign last_edge = (mode_q == QUAD_MODE) ? (edge_q == 4'd3) : (edge_q == 4'd15);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            active_q <= 1'b0;
            sck_q    <= 1'b0;
            done_q   <= 1'b0;
            edge_q   <= 4'd0;
            mode_q   <= SPI_MODE;
            drive_q  <= 1'b1;
        end else begin
            done_q <= active_q & last_edge;
            if (start_i) begin
                active_q <= 1'b1;
                sck_q    <= 1'b0;
                edge_q   <= 4'd0;
                mode_q   <= xfer_i.mode;
                drive_q  <= xfer_i.drive;
            end else if (active_q) begin
                sck_q  <= ~sck_q;
                edge_q <= edge_q + 4'd1;
                if (last_edge) begin
                    active_q <= 1'b0; // Ends on a falling edge, sck rests low
                end
            end
        end
    end

    // Sample and shift on the falling sck edge, the flash has held its
    // output stable for the whole high phase
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            shift_q <= xfer_i.data;
        end else if (active_q && sck_q) begin
            if (mode_q == QUAD_MODE) begin
                shift_q <= {shift_q[3:0], io_i};
            end else begin
                shift_q <= {shift_q[6:0], io_i[1]};
            end
        end
    end

    // SPI keeps WP and HOLD driven high, io1 is the input
    always_comb begin
        if (mode_q == QUAD_MODE) begin
            io_o    = shift_q[7:4];
            io_oe_o = {4{drive_q}};
        end else begin
            io_o    = {2'b11, 1'b0, shift_q[7]};
            io_oe_o = {2'b11, 1'b0, drive_q};
        end
    end

    assign busy_o = active_q;
    assign done_o = done_q;
    assign rx_o   = shift_q;
    assign sck_o  = sck_q;

    a_no_start_when_busy: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        start_i |-> !busy_o
    ) else $error("byte started while PHY busy");

endmodule

// ==== logic/flash_read_seq.sv ====
`timescale 1ns/1ns

module flash_read_seq (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 pend_i,
    input  qspi_pkg::read_req_t  req_i,
    output logic                 take_o,
    input  logic                 phy_busy_i,
    input  logic                 phy_done_i,
    input  logic [7:0]           phy_rx_i,
    output logic                 start_o,
    output qspi_pkg::byte_xfer_t xfer_o,
    output logic                 byte_valid_o,
    output qspi_pkg::rx_byte_t   byte_o,
    output logic                 cs_n_o,
    output logic                 busy_o
);
    import qspi_pkg::*;

    seq_state_e state_q;
    seq_state_e state_next;
    logic [9:0] cnt_q;      // Byte index within the current phase
    logic [9:0] last_idx_q; // Index of the final data byte
    logic [23:0] addr_q;
    byte_xfer_t xfer_q;
    rx_byte_t   byte_q;
    logic       start_q;
    logic       byte_valid_q;
    logic       cs_n_q;
    logic       data_last;

    assign take_o    = (state_q == S_IDLE) && pend_i && !phy_busy_i;
    assign data_last = (cnt_q == last_idx_q);

    // Phase after the byte that is finishing now
    always_comb begin
        state_next = state_q;
        case (state_q)
            S_CMD: state_next = S_ADDR;
            S_ADDR: begin
                if (cnt_q == 10'(ADDR_BYTES - 1)) begin
                    state_next = S_DUMMY;
                end
            end
            S_DUMMY: begin
                if (cnt_q == 10'(DUMMY_BYTES - 1)) begin
                    state_next = S_DATA;
                end
            end
            S_DATA: begin
                if (data_last) begin
                    state_next = S_END;
                end
            end
            default: state_next = state_q;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q      <= S_IDLE;
            cnt_q        <= 10'd0;
            start_q      <= 1'b0;
            byte_valid_q <= 1'b0;
            cs_n_q       <= 1'b1;
        end else begin
            start_q      <= 1'b0;
            byte_valid_q <= phy_done_i && (state_q == S_DATA);
            if (take_o) begin
                state_q <= S_CMD;
                cnt_q   <= 10'd0;
                start_q <= 1'b1;
                cs_n_q  <= 1'b0;
            end else if (state_q == S_END) begin
                if (cnt_q == 10'd1) begin // Two cycles of deselect
                    state_q <= S_IDLE;
                    cnt_q   <= 10'd0;
                end else begin
                    cnt_q <= cnt_q + 10'd1;
                end
            end else if (phy_done_i) begin
                state_q <= state_next;
                cnt_q   <= (state_next != state_q) ? 10'd0 : cnt_q + 10'd1;
                start_q <= (state_next != S_END);
                cs_n_q  <= (state_next == S_END);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (take_o) begin
            xfer_q     <= '{data: CMD_QUAD_READ, mode: SPI_MODE, drive: 1'b1};
            addr_q     <= req_i.addr;
            last_idx_q <= {req_i.words, 2'b00} - 10'd1;
        end else if (phy_done_i) begin
            byte_q <= '{data: phy_rx_i, last: data_last};
            if (state_next == S_ADDR) begin
                xfer_q <= '{data: addr_q[23:16], mode: SPI_MODE, drive: 1'b1}; // MSB first
                addr_q <= {addr_q[15:0], 8'h00};
            end else begin
                xfer_q <= '{data: 8'h00, mode: QUAD_MODE, drive: 1'b0}; // Dummy and data
            end
        end
    end

    assign start_o      = start_q;
    assign xfer_o       = xfer_q;
    assign byte_valid_o = byte_valid_q;
    assign byte_o       = byte_q;
    assign cs_n_o       = cs_n_q;
    assign busy_o       = pend_i || (state_q != S_IDLE); // Covers the waiting slot too

    a_cs_active: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (state_q != S_IDLE && state_q != S_END) |-> !cs_n_o
    ) else $error("chip select high during a transaction");

endmodule

// ==== logic/flash_word_pack.sv ====
`timescale 1ns/1ns

module flash_word_pack (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               byte_valid_i,
    input  qspi_pkg::rx_byte_t byte_i,
    output logic [31:0]        word_o,
    output logic               word_valid_o,
    output logic               read_done_o
);

    logic [1:0]  lane_q;
    logic [31:0] word_q;
    logic        word_valid_q;
    logic        read_done_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            lane_q       <= 2'd0;
            word_valid_q <= 1'b0;
            read_done_q  <= 1'b0;
        end else begin
            word_valid_q <= byte_valid_i && (lane_q == 2'd3);
            read_done_q  <= byte_valid_i && (lane_q == 2'd3) && byte_i.last;
            if (byte_valid_i) begin
                lane_q <= lane_q + 2'd1; // Wraps back to lane 0 after a word
            end
        end
    end

    // Little endian, first byte lands in bits 7:0
    always_ff @(posedge clk_i) begin
        if (byte_valid_i) begin
            word_q[lane_q*8 +: 8] <= byte_i.data;
        end
    end

    assign word_o       = word_q;
    assign word_valid_o = word_valid_q;
    assign read_done_o  = read_done_q;

    // Reads are whole words, so the last byte closes a word
    a_last_on_lane3: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (byte_valid_i && byte_i.last) |-> (lane_q == 2'd3)
    ) else $error("last byte not on lane 3");

endmodule

// ==== logic/qspi_flash_top.sv ====
`timescale 1ns/1ns

module qspi_flash_top (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                req_valid_i,
    input  qspi_pkg::read_req_t req_i,
    output logic [31:0]         word_o,
    output logic                word_valid_o,
    output logic                read_done_o,
    output logic                busy_o,
    output logic                drop_o,
    output logic                sck_o,
    output logic                cs_n_o,
    output logic [3:0]          io_o,
    output logic [3:0]          io_oe_o,
    input  logic [3:0]          io_i
);
    import qspi_pkg::*;

    read_req_t  slot_req;
    byte_xfer_t xfer;
    rx_byte_t   rx_byte;
    logic       pend;
    logic       take;
    logic       phy_start;
    logic       phy_busy;
    logic       phy_done;
    logic [7:0] phy_rx;
    logic       byte_valid;

    flash_read_req u_req (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .take_i      (take),
        .pend_o      (pend),
        .req_o       (slot_req),
        .drop_o      (drop_o)
    );

    flash_read_seq u_seq (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .pend_i       (pend),
        .req_i        (slot_req),
        .take_o       (take),
        .phy_busy_i   (phy_busy),
        .phy_done_i   (phy_done),
        .phy_rx_i     (phy_rx),
        .start_o      (phy_start),
        .xfer_o       (xfer),
        .byte_valid_o (byte_valid),
        .byte_o       (rx_byte),
        .cs_n_o       (cs_n_o),
        .busy_o       (busy_o)
    );

    qspi_byte_phy u_phy (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .start_i (phy_start),
        .xfer_i  (xfer),
        .busy_o  (phy_busy),
        .done_o  (phy_done),
        .rx_o    (phy_rx),
        .sck_o   (sck_o),
        .io_o    (io_o),
        .io_oe_o (io_oe_o),
        .io_i    (io_i)
    );

    flash_word_pack u_pack (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .byte_valid_i (byte_valid),
        .byte_i       (rx_byte),
        .word_o       (word_o),
        .word_valid_o (word_valid_o),
        .read_done_o  (read_done_o)
    );

endmodule

// ==== verification/flash_model.sv ====
`timescale 1ns/1ns

module flash_model (
    input  logic       sck_i,
    input  logic       cs_n_i,
    input  logic [3:0] io_i,    // Pins as driven by the controller
    input  logic [3:0] io_oe_i,
    output logic [3:0] io_o,    // Pins as driven by the flash
    output logic       err_o
);
    import qspi_pkg::*;

    int          edges;   // Rising sck edges since chip select fell
    logic [7:0]  cmd;
    logic [23:0] addr;
    logic        cmd_err;
    logic        len_err;
    logic        oe_err;

    // Array content, one byte per address
    function automatic logic [7:0] mem_byte(input logic [23:0] a);
        return (a[23:16] ^ a[15:8] ^ a[7:0]) + 8'h5A;
    endfunction

    initial begin
        io_o    = 4'h0;
        edges   = 0;
        cmd     = 8'h00;
        addr    = 24'h0;
        cmd_err = 1'b0;
        len_err = 1'b0;
        oe_err  = 1'b0;
    end

    // Command and address come in on io0, sampled on rising sck
    always @(posedge sck_i or posedge cs_n_i) begin
        if (cs_n_i) begin
            // 34 edges of header, then 8 edges per 32-bit word
            if (edges != 0 && (edges < 42 || (edges - 34) % 8 != 0)) begin
                len_err = 1'b1;
            end
            edges = 0;
        end else begin
            if (edges < 8) begin
                cmd = {cmd[6:0], io_i[0]};
                if (edges == 7 && cmd != CMD_QUAD_READ) begin
                    cmd_err = 1'b1;
                end
            end else if (edges < 32) begin
                addr = {addr[22:0], io_i[0]};
            end else if (io_oe_i != 4'h0) begin
                oe_err = 1'b1; // Dummy and data must leave the bus to the flash
            end
            edges = edges + 1;
        end
    end

    // Data nibbles change on falling sck, high nibble first
    always @(negedge sck_i) begin
        logic [23:0] cur;
        logic [7:0]  b;
        if (!cs_n_i && edges >= 34) begin
            cur  = addr + 24'((edges - 34) / 2);
            b    = mem_byte(cur);
            io_o = ((edges - 34) % 2 == 0) ? b[7:4] : b[3:0];
        end
    end

    assign err_o = cmd_err | len_err | oe_err;

endmodule

// ==== verification/tb_qspi_flash.sv ====
`timescale 1ns/1ns

module tb_qspi_flash;
    import qspi_pkg::*;

    typedef struct packed {
        logic [23:0] addr;
        logic [7:0]  words;
        logic [3:0]  gap;  // 0 waits for idle, else cycles after the last request
        logic        drop; // Request is expected to be lost
    } stim_t;

    localparam int N_STIM = 11;
    localparam int TIMEOUT = 2000;

    logic        clk_i;
    logic        rst_n_i;
    logic        req_valid_i;
    read_req_t   req_i;
    logic [31:0] word_o;
    logic        word_valid_o;
    logic        read_done_o;
    logic        busy_o;
    logic        drop_o;
    logic        sck_o;
    logic        cs_n_o;
    logic [3:0]  io_o;
    logic [3:0]  io_oe_o;
    logic [3:0]  io_i;
    logic        model_err;

    stim_t       table_q [N_STIM];
    logic [31:0] exp_words [$];
    logic        exp_last [$];
    logic        drop_exp;
    logic [31:0] lfsr;

    qspi_flash_top dut0 (.*);

    flash_model u_flash (
        .sck_i   (sck_o),
        .cs_n_i  (cs_n_o),
        .io_i    (io_o),
        .io_oe_i (io_oe_o),
        .io_o    (io_i),
        .err_o   (model_err)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    function automatic logic [7:0] expected_byte(input logic [23:0] a);
        return (a[23:16] ^ a[15:8] ^ a[7:0]) + 8'h5A;
    endfunction

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = 32'h0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
    endtask

    task automatic timed_out(input string what);
        $display("Timeout while waiting for %s", what);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    // Output checks on the falling edge before the inputs change
    task automatic tick();
        @(negedge clk_i);
        req_valid_i = 1'b0;
        check("model error", 32'd0, {31'd0, model_err});
        check("drop", {31'd0, drop_exp}, {31'd0, drop_o});
        drop_exp = 1'b0;
        if (exp_words.size() != 0) begin
            check("busy during read", 32'd1, {31'd0, busy_o});
        end
        if (word_valid_o) begin
            if (exp_words.size() == 0) begin
                $display("Word returned with no read outstanding");
                $display("*** TEST FAILED ***");
                $fatal(1);
            end
            check("word", exp_words.pop_front(), word_o);
            check("read done", {31'd0, exp_last.pop_front()}, {31'd0, read_done_o});
        end else begin
            check("read done without word", 32'd0, {31'd0, read_done_o});
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (exp_words.size() != 0 || busy_o) begin
            if (n == TIMEOUT) timed_out("the controller to go idle");
            tick();
            n++;
        end
    endtask

    task automatic issue(input stim_t s);
        logic [23:0] a;
        logic [31:0] w;
        req_i       = '{addr: s.addr, words: s.words};
        req_valid_i = 1'b1;
        if (s.drop) begin
            drop_exp = 1'b1;
        end else begin
            for (int i = 0; i < int'(s.words); i++) begin
                for (int k = 0; k < 4; k++) begin
                    a = s.addr + 24'(i * 4 + k);
                    w[k*8 +: 8] = expected_byte(a);
                end
                exp_words.push_back(w);
                exp_last.push_back(i == int'(s.words) - 1);
            end
        end
    endtask

    initial begin
        lfsr        = 32'h187720c5;
        drop_exp    = 1'b0;
        rst_n_i     = 1'b0;
        req_valid_i = 1'b0;
        req_i       = '0;
        table_q[0] = '{addr: 24'h000100, words: 8'd1, gap: 4'd0, drop: 1'b0};
        table_q[1] = '{addr: 24'h0000F8, words: 8'd4, gap: 4'd0, drop: 1'b0}; // Crosses 0x100
        table_q[2] = '{addr: 24'h001234, words: 8'd2, gap: 4'd0, drop: 1'b0};
        table_q[3] = '{addr: 24'h00ABC0, words: 8'd3, gap: 4'd1, drop: 1'b0};
        table_q[4] = '{addr: 24'h123456, words: 8'd1, gap: 4'd1, drop: 1'b1};
        for (int i = 5; i < N_STIM; i++) begin
            table_q[i].addr  = 24'(random_bits(24));
            table_q[i].words = 8'(random_bits(3)) + 8'd1;
            table_q[i].gap   = 4'd0;
            table_q[i].drop  = 1'b0;
        end

        repeat (16) @(negedge clk_i);
        check("reset cs_n", 32'd1, {31'd0, cs_n_o});
        check("reset sck", 32'd0, {31'd0, sck_o});
        check("reset io_oe", 32'hD, {28'd0, io_oe_o});
        check("reset io high", 32'h3, {30'd0, io_o[3:2]});
        check("reset word_valid", 32'd0, {31'd0, word_valid_o});
        rst_n_i = 1'b1;

        for (int i = 0; i < N_STIM; i++) begin
            if (table_q[i].gap == 4'd0) begin
                wait_idle();
            end else begin
                repeat (int'(table_q[i].gap)) tick();
            end
            issue(table_q[i]);
        end
        tick();
        wait_idle();
        repeat (4) tick();

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== vlog.f ====
logic/qspi_pkg.sv
logic/flash_read_req.sv
logic/qspi_byte_phy.sv
logic/flash_read_seq.sv
logic/flash_word_pack.sv
logic/qspi_flash_top.sv
verification/flash_model.sv
verification/tb_qspi_flash.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the QSPI flash controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_qspi_flash -o sim_tb

./obj_dir/sim_tb | tee sim.log

grep -qF "*** TEST PASSED ***" sim.log
